/* Makefile */
# Verilator build and run of the response bank testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_simmem_rsp_bank
FLIST     := flist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

# Sources from the file list, plus the included check helpers
SOURCES := $(shell grep -v '^+' $(FLIST)) tb_simmem_checks.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+.
simmem_pkg.sv
simmem_rsp_ingress.sv
simmem_linkedlist_store.sv
simmem_rsp_release.sv
simmem_rsp_bank.sv
tb_simmem_rsp_bank.sv

/* simmem_linkedlist_store.sv */
// Slot storage of the response bank
// Payloads and next pointers live in flip-flop arrays indexed by slot,
// chained into one list per identifier with head, tail and length.
// Pushes come from the ingress, pops from the release stage

module simmem_linkedlist_store #(
  parameter int unsigned Capacity = simmem_pkg::DEFAULT_CAPACITY,
  localparam int unsigned SlotW = (Capacity > 1) ? $clog2(Capacity) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Write of a newly accepted response
  input  logic                       i_push_valid,
  input  simmem_pkg::rsp_t           i_push_rsp,
  input  logic [SlotW-1:0]           i_push_slot,

  // Removal of the head of one list
  input  logic                       i_pop_valid,
  input  simmem_pkg::id_t            i_pop_id,

  // List state towards the release stage
  output simmem_pkg::id_mask_t       o_nonempty,
  output simmem_pkg::head_payloads_t o_head_payloads,

  // Slot given back to the ingress
  output logic                       o_free_valid,
  output logic [SlotW-1:0]           o_free_slot
);

  // Length must reach Capacity itself
  localparam int unsigned LenW = $clog2(Capacity + 1);

  ////////////////////////////////////////////////////////////
  // Slot arrays
  ////////////////////////////////////////////////////////////

  // Response bodies without identifier, which the list implies
  simmem_pkg::payload_t payload_q [Capacity];

  // Following slot in the same list
  logic [SlotW-1:0]     next_q    [Capacity];

  // Per identifier pointers and lengths
  logic [SlotW-1:0] head_d [simmem_pkg::NUM_IDS];
  logic [SlotW-1:0] head_q [simmem_pkg::NUM_IDS];
  logic [SlotW-1:0] tail_d [simmem_pkg::NUM_IDS];
  logic [SlotW-1:0] tail_q [simmem_pkg::NUM_IDS];
  logic [LenW-1:0]  len_d  [simmem_pkg::NUM_IDS];
  logic [LenW-1:0]  len_q  [simmem_pkg::NUM_IDS];

  // Old tail needs a link when its list already holds something
  logic link_tail;

  assign link_tail = i_push_valid && (len_q[i_push_rsp.id] != '0);

  // Payload and link written when a response arrives
  always_ff @(posedge clk_i) begin
    if (i_push_valid) begin
      payload_q[i_push_slot] <= i_push_rsp.payload;
    end
    if (link_tail) begin
      next_q[tail_q[i_push_rsp.id]] <= i_push_slot;
    end
  end

  ////////////////////////////////////////////////////////////
  // Per identifier list update
  ////////////////////////////////////////////////////////////

  for (genvar i_id = 0; i_id < simmem_pkg::NUM_IDS; i_id++) begin : g_list
    logic push_here;
    logic pop_here;

    assign push_here = i_push_valid && (i_push_rsp.id == simmem_pkg::id_t'(i_id));
    assign pop_here  = i_pop_valid && (i_pop_id == simmem_pkg::id_t'(i_id));

    always_comb begin
      head_d[i_id] = head_q[i_id];
      tail_d[i_id] = tail_q[i_id];
      len_d[i_id]  = len_q[i_id];

      // New response always becomes the tail
      if (push_here) begin
        tail_d[i_id] = i_push_slot;
        // In an empty list the new slot is also the head
        if (len_q[i_id] == '0) begin
          head_d[i_id] = i_push_slot;
        end
        len_d[i_id] = len_d[i_id] + LenW'(1);
      end

      if (pop_here) begin
        // Single entry replaced in the same cycle
        // Head jumps straight to the new slot because the old tail has no link yet
        if (push_here && (len_q[i_id] == LenW'(1))) begin
          head_d[i_id] = i_push_slot;
        end else begin
          head_d[i_id] = next_q[head_q[i_id]];
        end
        len_d[i_id] = len_d[i_id] - LenW'(1);
      end
    end

    // Registered lengths drive the release decision
    assign o_nonempty[i_id] = (len_q[i_id] != '0);

    // Asynchronous read of each head
    assign o_head_payloads[i_id] = payload_q[head_q[i_id]];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '{default: '0};
      tail_q <= '{default: '0};
      len_q  <= '{default: '0};
    end else begin
      head_q <= head_d;
      tail_q <= tail_d;
      len_q  <= len_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Slot release
  ////////////////////////////////////////////////////////////

  // The popped head goes back to the ingress on the same edge
  assign o_free_valid = i_pop_valid;
  assign o_free_slot  = head_q[i_pop_id];

endmodule

/* simmem_pkg.sv */
// Shared widths and types for the write response bank
// Included first in compile order, referenced by scoped names
// by the RTL modules and by the testbench

package simmem_pkg;

  ////////////////////////////////////////////////////////////
  // Identifier and payload widths
  ////////////////////////////////////////////////////////////

  // Width of an AXI write response identifier
  localparam int unsigned ID_W = 2;

  // One linked list per identifier value
  localparam int unsigned NUM_IDS = 2 ** ID_W;

  // Response body, identifier excluded
  localparam int unsigned PAYLOAD_W = 8;

  // Slot count used by the top level unless overridden
  localparam int unsigned DEFAULT_CAPACITY = 8;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // AXI identifier
  typedef logic [ID_W-1:0] id_t;

  // Response body
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Full response as carried on both ports and between blocks
  // Identifier sits in the upper bits
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } rsp_t;

  // One head payload per identifier, towards the release stage
  typedef payload_t [NUM_IDS-1:0] head_payloads_t;

  // One flag per identifier
  typedef logic [NUM_IDS-1:0] id_mask_t;

endpackage

/* simmem_rsp_bank.sv */
// Write response bank of the simulated memory controller
// Responses are stored per AXI identifier in shared slots and leave in
// arrival order within an identifier, lowest identifier first

module simmem_rsp_bank #(
  parameter int unsigned Capacity = simmem_pkg::DEFAULT_CAPACITY,
  localparam int unsigned SlotW = (Capacity > 1) ? $clog2(Capacity) : 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Incoming responses
  input  simmem_pkg::rsp_t i_rsp,
  input  logic             i_rsp_valid,
  output logic             o_rsp_ready,

  // Outgoing responses
  output simmem_pkg::rsp_t o_rsp,
  output logic             o_rsp_valid,
  input  logic             i_out_ready
);

  // Ingress to store
  logic                       push_valid;
  simmem_pkg::rsp_t           push_rsp;
  logic [SlotW-1:0]           push_slot;

  // Store to ingress
  logic                       free_valid;
  logic [SlotW-1:0]           free_slot;

  // Store and release stage
  simmem_pkg::id_mask_t       nonempty;
  simmem_pkg::head_payloads_t head_payloads;
  logic                       pop_valid;
  simmem_pkg::id_t            pop_id;

  // Slot allocation
  simmem_rsp_ingress #(
    .Capacity(Capacity)
  ) simmem_rsp_ingress_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_rsp       (i_rsp),
    .i_rsp_valid (i_rsp_valid),
    .o_rsp_ready (o_rsp_ready),
    .i_free_valid(free_valid),
    .i_free_slot (free_slot),
    .o_push_valid(push_valid),
    .o_push_rsp  (push_rsp),
    .o_push_slot (push_slot)
  );

  // Linked lists
  simmem_linkedlist_store #(
    .Capacity(Capacity)
  ) simmem_linkedlist_store_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_push_valid   (push_valid),
    .i_push_rsp     (push_rsp),
    .i_push_slot    (push_slot),
    .i_pop_valid    (pop_valid),
    .i_pop_id       (pop_id),
    .o_nonempty     (nonempty),
    .o_head_payloads(head_payloads),
    .o_free_valid   (free_valid),
    .o_free_slot    (free_slot)
  );

  // Release and output register
  simmem_rsp_release simmem_rsp_release_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_nonempty     (nonempty),
    .i_head_payloads(head_payloads),
    .o_pop_valid    (pop_valid),
    .o_pop_id       (pop_id),
    .o_rsp          (o_rsp),
    .o_rsp_valid    (o_rsp_valid),
    .i_out_ready    (i_out_ready)
  );

endmodule

/* simmem_rsp_ingress.sv */
// Input side of the response bank
// Tracks which slots hold a response and hands the lowest free one
// to each accepted response, pushing it into the linked-list store

module simmem_rsp_ingress #(
  parameter int unsigned Capacity = simmem_pkg::DEFAULT_CAPACITY,
  localparam int unsigned SlotW = (Capacity > 1) ? $clog2(Capacity) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Incoming responses
  input  simmem_pkg::rsp_t  i_rsp,
  input  logic              i_rsp_valid,
  output logic              o_rsp_ready,

  // Slot released by a pop in the store
  input  logic              i_free_valid,
  input  logic [SlotW-1:0]  i_free_slot,

  // Write request towards the store
  output logic              o_push_valid,
  output simmem_pkg::rsp_t  o_push_rsp,
  output logic [SlotW-1:0]  o_push_slot
);

  // One bit per slot, set while the slot holds a response
  logic [Capacity-1:0] occ_d;
  logic [Capacity-1:0] occ_q;

  // Lowest clear occupancy bit, one-hot, all zero when full
  logic [Capacity-1:0] free_onehot;
  logic [SlotW-1:0]    free_slot;

  ////////////////////////////////////////////////////////////
  // Lowest free slot
  ////////////////////////////////////////////////////////////

  // A slot wins when it is free and every slot below it is taken
  for (genvar i_slot = 0; i_slot < Capacity; i_slot++) begin : g_free_onehot
    if (i_slot == 0) begin : g_first
      assign free_onehot[i_slot] = ~occ_q[0];
    end else begin : g_rest
      assign free_onehot[i_slot] = ~occ_q[i_slot] & (&occ_q[i_slot-1:0]);
    end
  end

  // One-hot to binary
  always_comb begin
    free_slot = '0;
    for (int unsigned i_slot = 0; i_slot < Capacity; i_slot++) begin
      if (free_onehot[i_slot]) begin
        free_slot = SlotW'(i_slot);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake and occupancy
  ////////////////////////////////////////////////////////////

  // Ready only depends on registered occupancy
  assign o_rsp_ready = |free_onehot;

  // Accept and push in the same cycle
  assign o_push_valid = i_rsp_valid & o_rsp_ready;
  assign o_push_rsp   = i_rsp;
  assign o_push_slot  = free_slot;

  // The pushed slot is free and the freed slot is taken, so they never collide
  always_comb begin
    occ_d = occ_q;
    if (o_push_valid) begin
      occ_d[free_slot] = 1'b1;
    end
    if (i_free_valid) begin
      occ_d[i_free_slot] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

/* simmem_rsp_release.sv */
// Output side of the response bank
// Picks the lowest identifier with a waiting response, pops its head
// and holds it in the output register until the consumer takes it

module simmem_rsp_release (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // List state from the store
  input  simmem_pkg::id_mask_t       i_nonempty,
  input  simmem_pkg::head_payloads_t i_head_payloads,

  // Pop request towards the store
  output logic                       o_pop_valid,
  output simmem_pkg::id_t            o_pop_id,

  // Outgoing responses
  output simmem_pkg::rsp_t           o_rsp,
  output logic                       o_rsp_valid,
  input  logic                       i_out_ready
);

  // Output register
  simmem_pkg::rsp_t rsp_q;
  logic             rsp_valid_q;

  // Lowest non-empty identifier
  simmem_pkg::id_t  sel_id;

  // Register empty or handing off this cycle
  logic             can_load;

  ////////////////////////////////////////////////////////////
  // Identifier selection
  ////////////////////////////////////////////////////////////

  // Scan from the top so the lowest set bit wins
  always_comb begin
    sel_id = '0;
    for (int i_id = simmem_pkg::NUM_IDS - 1; i_id >= 0; i_id--) begin
      if (i_nonempty[i_id]) begin
        sel_id = simmem_pkg::id_t'(i_id);
      end
    end
  end

  assign can_load = !rsp_valid_q || i_out_ready;

  // Pop whenever the register can accept a new response
  assign o_pop_valid = can_load && (|i_nonempty);
  assign o_pop_id    = sel_id;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  // Valid follows the pop decision on every load opportunity
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (can_load) begin
      rsp_valid_q <= |i_nonempty;
    end
  end

  // Content only changes on a pop, stays put under back-pressure
  always_ff @(posedge clk_i) begin
    if (o_pop_valid) begin
      rsp_q.id      <= sel_id;
      rsp_q.payload <= i_head_payloads[sel_id];
    end
  end

  assign o_rsp       = rsp_q;
  assign o_rsp_valid = rsp_valid_q;

endmodule

/* tb_simmem_checks.svh */
// Check helpers for the response bank testbench
// Included inside the testbench module, after its signal declarations.
// Holds the reference queues, error counters, compare tasks and bounded waits
`ifndef TB_SIMMEM_CHECKS_SVH
`define TB_SIMMEM_CHECKS_SVH

  // Wrong values and other failures, reported together at the end
  int unsigned mismatch_count = 0;
  int unsigned error_count = 0;

  // Expected responses, one queue per identifier in acceptance order
  simmem_pkg::rsp_t ref_q [simmem_pkg::NUM_IDS][$];

  task automatic compare_rsp(input string name, input simmem_pkg::rsp_t exp,
                             input simmem_pkg::rsp_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("mismatch %s: expected id %0d payload 0x%02h, actual id %0d payload 0x%02h",
               name, exp.id, exp.payload, act.id, act.payload);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_count++;
      $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int unsigned exp,
                               input int unsigned act);
    if (act != exp) begin
      mismatch_count++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Responses still owed by the DUT
  function automatic int unsigned pending_count();
    int unsigned total;
    total = 0;
    for (int i_id = 0; i_id < simmem_pkg::NUM_IDS; i_id++) begin
      total += ref_q[i_id].size();
    end
    return total;
  endfunction

  // Output must be the oldest response of its own identifier
  task automatic check_against_ref(input string name);
    simmem_pkg::id_t id;
    id = rsp_out.id;
    if (ref_q[id].size() == 0) begin
      error_count++;
      $display("%s: response with id %0d came out but none was waiting for that id", name, id);
    end else begin
      compare_rsp(name, ref_q[id].pop_front(), rsp_out);
    end
  endtask

  // Both waits return at a falling edge, handshake follows on the next rising edge
  task automatic wait_in_ready(input string name, output bit ok);
    int unsigned cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WaitLimit) begin
      @(negedge clk_i);
      ok = rsp_in_ready;
      cycles++;
    end
    if (!ok) begin
      error_count++;
      $display("%s: timed out waiting for the bank to accept a response", name);
    end
  endtask

  task automatic wait_out_valid(input string name, output bit ok);
    int unsigned cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WaitLimit) begin
      @(negedge clk_i);
      ok = rsp_out_valid;
      cycles++;
    end
    if (!ok) begin
      error_count++;
      $display("%s: timed out waiting for a response on the output", name);
    end
  endtask

`endif

/* tb_simmem_rsp_bank.sv */
// Directed testbench for the write response bank
// Inputs change 1 unit after the rising edge, outputs are sampled on the
// falling edge. Every task starts and ends just after a rising edge

module tb_simmem_rsp_bank;

  localparam int unsigned Capacity = simmem_pkg::DEFAULT_CAPACITY;

  // Bound on any single wait, in clock cycles
  localparam int unsigned WaitLimit = 64;

  // Responses in the random order run
  localparam int unsigned NumRandom = 200;

  logic             clk_i;
  logic             rst_ni;
  simmem_pkg::rsp_t rsp_in;
  logic             rsp_in_valid;
  logic             rsp_in_ready;
  simmem_pkg::rsp_t rsp_out;
  logic             rsp_out_valid;
  logic             rsp_out_ready;

  `include "tb_simmem_checks.svh"

  simmem_rsp_bank #(
    .Capacity(Capacity)
  ) simmem_rsp_bank_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_rsp      (rsp_in),
    .i_rsp_valid(rsp_in_valid),
    .o_rsp_ready(rsp_in_ready),
    .o_rsp      (rsp_out),
    .o_rsp_valid(rsp_out_valid),
    .i_out_ready(rsp_out_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic simmem_pkg::rsp_t make_rsp(input simmem_pkg::id_t id,
                                                input simmem_pkg::payload_t payload);
    simmem_pkg::rsp_t rsp;
    rsp.id      = id;
    rsp.payload = payload;
    return rsp;
  endfunction

  task automatic to_drive_point();
    @(posedge clk_i);
    #1;
  endtask

  // Leaves valid high for the caller to decide what comes next
  task automatic offer_rsp(input string name, input simmem_pkg::rsp_t rsp, output bit ok);
    rsp_in       = rsp;
    rsp_in_valid = 1'b1;
    wait_in_ready(name, ok);
    if (ok) begin
      ref_q[rsp.id].push_back(rsp);
    end
    to_drive_point();
  endtask

  task automatic send_rsp(input string name, input simmem_pkg::rsp_t rsp);
    bit ok;
    offer_rsp(name, rsp, ok);
    rsp_in_valid = 1'b0;
  endtask

  // Takes one response with the output ready held high by the caller
  task automatic receive_expected(input string name, input simmem_pkg::rsp_t exp);
    bit ok;
    wait_out_valid(name, ok);
    if (ok) begin
      compare_rsp(name, exp, rsp_out);
      if (ref_q[exp.id].size() != 0) begin
        void'(ref_q[exp.id].pop_front());
      end
    end
    to_drive_point();
  endtask

  // Empties the bank, checking each output against the reference queues
  task automatic drain_all(input string name);
    int unsigned cycles;
    cycles = 0;
    rsp_out_ready = 1'b1;
    while (pending_count() != 0 && cycles < WaitLimit) begin
      @(negedge clk_i);
      if (rsp_out_valid) begin
        check_against_ref(name);
      end
      cycles++;
    end
    if (pending_count() != 0) begin
      error_count++;
      $display("%s: timed out with %0d responses still inside", name, pending_count());
    end
    to_drive_point();
    rsp_out_ready = 1'b0;
    compare_bit({name, " output empty"}, 1'b0, rsp_out_valid);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    @(negedge clk_i);
    compare_bit("reset_state o_rsp_valid", 1'b0, rsp_out_valid);
    compare_bit("reset_state o_rsp_ready", 1'b1, rsp_in_ready);
    to_drive_point();
    send_rsp("reset_state", make_rsp(2'd2, 8'h5a));
    drain_all("reset_state");
  endtask

  task automatic run_random_order();
    int unsigned received;
    int unsigned cycles;
    bit ok;
    simmem_pkg::rsp_t rsp;
    fork
      // Producer with occasional idle cycles
      begin
        for (int k = 0; k < NumRandom; k++) begin
          rsp = make_rsp(simmem_pkg::id_t'($urandom), simmem_pkg::payload_t'($urandom));
          offer_rsp("random_order", rsp, ok);
          if (!ok) begin
            break;
          end
          if ($urandom % 4 == 0) begin
            rsp_in_valid = 1'b0;
            to_drive_point();
          end
        end
        rsp_in_valid = 1'b0;
      end
      // Consumer with random back-pressure
      begin
        received = 0;
        cycles = 0;
        while (received < NumRandom && cycles < NumRandom * 40) begin
          rsp_out_ready = 1'($urandom);
          @(negedge clk_i);
          if (rsp_out_valid && rsp_out_ready) begin
            check_against_ref("random_order");
            received++;
          end
          to_drive_point();
          cycles++;
        end
        if (received < NumRandom) begin
          error_count++;
          $display("random_order: timed out after %0d of %0d responses", received, NumRandom);
        end
      end
    join
    rsp_out_ready = 1'b0;
  endtask

  // Id 3 reaches the output register alone while the others wait in their lists
  task automatic check_id_priority();
    rsp_out_ready = 1'b0;
    send_rsp("id_priority", make_rsp(2'd3, 8'h33));
    send_rsp("id_priority", make_rsp(2'd1, 8'h11));
    send_rsp("id_priority", make_rsp(2'd2, 8'h22));
    send_rsp("id_priority", make_rsp(2'd0, 8'h00));
    rsp_out_ready = 1'b1;
    receive_expected("id_priority first", make_rsp(2'd3, 8'h33));
    receive_expected("id_priority second", make_rsp(2'd0, 8'h00));
    receive_expected("id_priority third", make_rsp(2'd1, 8'h11));
    receive_expected("id_priority fourth", make_rsp(2'd2, 8'h22));
    rsp_out_ready = 1'b0;
  endtask

  task automatic fill_bank();
    int unsigned accepted;
    int unsigned cycles;
    bit full;
    accepted = 0;
    cycles = 0;
    full = 1'b0;
    rsp_out_ready = 1'b0;
    rsp_in = make_rsp(2'd0, 8'h40);
    rsp_in_valid = 1'b1;
    while (!full && cycles < 4 * Capacity) begin
      @(negedge clk_i);
      if (rsp_in_ready) begin
        ref_q[rsp_in.id].push_back(rsp_in);
        accepted++;
        to_drive_point();
        rsp_in = make_rsp(simmem_pkg::id_t'(accepted),
                          simmem_pkg::payload_t'(8'h40 + accepted));
      end else begin
        full = 1'b1;
      end
      cycles++;
    end
    if (full) begin
      to_drive_point();
    end
    // All slots plus the output register
    compare_count("fill_bank acceptances", Capacity + 1, accepted);
    @(negedge clk_i);
    compare_bit("fill_bank ready stays low", 1'b0, rsp_in_ready);
    to_drive_point();
    rsp_in_valid = 1'b0;
    rsp_out_ready = 1'b1;
    @(negedge clk_i);
    if (rsp_out_valid) begin
      check_against_ref("fill_bank first delivery");
    end else begin
      error_count++;
      $display("fill_bank: full bank shows no response on its output");
    end
    to_drive_point();
    rsp_out_ready = 1'b0;
    @(negedge clk_i);
    compare_bit("fill_bank ready after delivery", 1'b1, rsp_in_ready);
    to_drive_point();
    drain_all("fill_bank");
  endtask

  // Second response of the same id sits behind the held one
  task automatic hold_under_backpressure();
    simmem_pkg::rsp_t held;
    int unsigned hold_cycles;
    bit ok;
    held = make_rsp(2'd1, 8'hc3);
    rsp_out_ready = 1'b0;
    send_rsp("stable_output", held);
    send_rsp("stable_output", make_rsp(2'd1, 8'h3c));
    wait_out_valid("stable_output", ok);
    compare_rsp("stable_output first o_rsp", held, rsp_out);
    hold_cycles = 3 + ($urandom % 6);
    repeat (hold_cycles) begin
      @(negedge clk_i);
      compare_bit("stable_output o_rsp_valid", 1'b1, rsp_out_valid);
      compare_rsp("stable_output o_rsp", held, rsp_out);
    end
    to_drive_point();
    drain_all("stable_output");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(84));
    rst_ni        = 1'b0;
    rsp_in        = '0;
    rsp_in_valid  = 1'b0;
    rsp_out_ready = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_reset_state();
    run_random_order();
    check_id_priority();
    fill_bank();
    hold_under_backpressure();

    $display("mismatches %0d, other errors %0d", mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
